/* sources.f */
verilog/switch_cfg_pkg.sv
verilog/switch_hdr_pkg.sv
verilog/priority_decoder.sv
verilog/priority_ranker.sv
verilog/dest_filter.sv
verilog/grant_select.sv
verilog/apb_regs.sv
verilog/switch_arbiter_top.sv
test/tb_switch_arbiter.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_switch_arbiter
FILELIST  = sources.f
OBJDIR    = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | awk '{ print } /Simulation completed successfully/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJDIR)

/* test/tb_switch_arbiter.sv */
module tb_switch_arbiter
    import switch_cfg_pkg::*;
    import switch_hdr_pkg::*;
();

    localparam int num_ports  = num_ports_default;
    localparam int num_levels = num_levels_default;
    localparam int wait_limit = 50;  // cycles per wait.

    typedef struct packed {
        logic [15:0] ready;
        logic [63:0] prio;    // one nibble per port, port 0 lowest.
        logic [63:0] dest;    // one nibble per port.
        logic [15:0] busy;
        logic [15:0] enable;
        logic        none;    // no grant expected.
        logic [3:0]  port;
    } entry_t;

    logic                    clk;
    logic                    rst;
    logic [num_ports*64-1:0] hdr_words;
    logic [num_ports-1:0]    ready;
    logic [num_ports-1:0]    eop;
    logic [num_ports-1:0]    dest_busy;
    apb_req_t                apb_req;
    grant_t                  grant;
    apb_rsp_t                apb_rsp;

    entry_t      stim[$];
    logic [7:0]  lens[num_ports];
    logic [31:0] rng;
    int          grant_count;
    logic [3:0]  last_port;

    switch_arbiter_top #(.num_ports(num_ports), .num_levels(num_levels)) uut (
        .clk(clk), .rst(rst), .hdr_words(hdr_words), .ready(ready), .eop(eop),
        .dest_busy(dest_busy), .apb_req(apb_req), .grant(grant), .apb_rsp(apb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ********************
    // helpers
    // ********************

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;  // drive and sample just after the edge.
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_grant(input grant_t got, input grant_t exp, input string what);
        if (got.valid !== exp.valid || (exp.valid && (got.port !== exp.port
                || got.dest !== exp.dest || got.length !== exp.length))) begin
            abort_run($sformatf(
                "FAIL at %0t: %s: got v%0b p%0d d%0d l%0d, expected v%0b p%0d d%0d l%0d",
                $time, what, got.valid, got.port, got.dest, got.length,
                exp.valid, exp.port, exp.dest, exp.length));
        end
    endtask

    task automatic check_reg(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("FAIL at %0t: %s: got %08h, expected %08h",
                $time, what, got, exp));
        end
    endtask

    task automatic check_status(input apb_rsp_t got, input string what);
        if (got.pready !== 1'b1 || got.pslverr !== 1'b0) begin
            abort_run($sformatf("FAIL at %0t: %s: pready %0b pslverr %0b, expected 1 and 0",
                $time, what, got.pready, got.pslverr));
        end
    endtask

    task automatic apb_write(input reg_addr_e addr, input logic [31:0] data);
        tick();
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
        tick();
        apb_req.penable = 1'b1;
        #1;
        check_status(apb_rsp, "write response");
        tick();
        apb_req = '0;
    endtask

    task automatic apb_read(input reg_addr_e addr, output logic [31:0] data);
        tick();
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'd0};
        tick();
        apb_req.penable = 1'b1;
        #1 data = apb_rsp.prdata;
        check_status(apb_rsp, "read response");
        tick();
        apb_req = '0;
    endtask

    task automatic wait_grant();
        int n;
        n = 0;
        while (!grant.valid) begin
            if (n == wait_limit) abort_run("timeout while waiting for grant.valid to rise");
            else tick();
            n++;
        end
    endtask

    task automatic wait_decoder_empty();
        int n;
        n = 0;
        while (uut.u_decoder.hdr_valid) begin
            if (n == wait_limit) abort_run("timeout while waiting for the decoder to release");
            else tick();
            n++;
        end
    endtask

    task automatic expect_no_grant();
        for (int n = 0; n < wait_limit; n++) begin
            tick();
            if (grant.valid) begin
                abort_run($sformatf("FAIL at %0t: unexpected grant to port %0d",
                    $time, grant.port));
            end
        end
    endtask

    task automatic fill_headers(input entry_t e);
        for (int p = 0; p < num_ports; p++) begin
            rng     = xorshift32(rng);
            lens[p] = rng[7:0];
            rng     = xorshift32(rng);  // upper bits are don't care.
            hdr_words[p*64 +: 64] = {rng, rng[16:0], lens[p], e.prio[p*4 +: 3], e.dest[p*4 +: 4]};
        end
    endtask

    task automatic add_entry(input logic [15:0] rdy, input logic [63:0] prio,
            input logic [63:0] dest, input logic [15:0] busy, input logic [15:0] enable,
            input logic none, input logic [3:0] port);
        stim.push_back({rdy, prio, dest, busy, enable, none, port});
    endtask

    // ********************
    // one table entry
    // ********************

    task automatic run_entry(input entry_t e);
        grant_t exp;
        ready = '0;
        eop   = '0;
        wait_decoder_empty();
        apb_write(reg_port_enable, 32'(e.enable));
        fill_headers(e);
        dest_busy = e.busy;
        ready     = e.ready;
        if (e.none) begin
            expect_no_grant();
        end else begin
            exp = '{valid: 1'b1, port: e.port, dest: e.dest[e.port*4 +: 4], length: lens[e.port]};
            wait_grant();
            check_grant(grant, exp, "new grant");
            grant_count++;
            last_port = e.port;
            for (int n = 0; n < 3; n++) begin
                fill_headers(e);
                eop = ~(16'd1 << e.port);  // eop on every other port.
                tick();
                check_grant(grant, exp, "held grant");
            end
            eop = 16'd1 << e.port;
            tick();
            ready = '0;
            eop   = '0;
            check_grant(grant, grant_t'('0), "grant after eop");
        end
    endtask

    initial begin
        logic [31:0] data;
        rst         = 1'b1;
        hdr_words   = '0;
        ready       = '0;
        eop         = '0;
        dest_busy   = '0;
        apb_req     = '0;
        rng         = 32'd24;
        grant_count = 0;
        last_port   = '0;
        repeat (8) tick();
        rst = 1'b0;
        check_grant(grant, grant_t'('0), "grant after reset");
        apb_read(reg_port_enable, data);
        check_reg(data, 32'h0000_ffff, "port_enable after reset");

        add_entry(16'h00f0, 64'h0000_0000_2351_0000, 64'h0000_0000_cba9_0000,
                  16'h0000, 16'hffff, 1'b0, 4'd5);
        add_entry(16'h8003, 64'h4000_0000_0000_0062, 64'h1000_0000_0000_0032,
                  16'h0000, 16'hffff, 1'b0, 4'd1);
        add_entry(16'hffff, 64'h3333_3333_3333_3333, 64'h0123_4567_89ab_cdef,
                  16'h0000, 16'hffff, 1'b0, 4'd2);
        add_entry(16'hffff, 64'h3333_3333_3333_3333, 64'h0123_4567_89ab_cdef,
                  16'h0000, 16'hffff, 1'b0, 4'd3);
        add_entry(16'hffff, 64'h3333_3333_3333_3333, 64'h0123_4567_89ab_cdef,
                  16'h0000, 16'hffff, 1'b0, 4'd4);
        add_entry(16'hffff, 64'h3333_3333_3333_3333, 64'h0123_4567_89ab_cdef,
                  16'h0400, 16'hffff, 1'b0, 4'd6);
        add_entry(16'hffff, 64'h3333_3333_3333_3333, 64'h0123_4567_89ab_cdef,
                  16'h0000, 16'hfe7f, 1'b0, 4'd9);
        add_entry(16'h0c00, 64'h0000_1700_0000_0000, 64'h0000_4300_0000_0000,
                  16'h0008, 16'hffff, 1'b0, 4'd11);
        add_entry(16'h0003, 64'h0000_0000_0000_0000, 64'h0000_0000_0000_0022,
                  16'h0004, 16'hffff, 1'b1, 4'd0);
        add_entry(16'h0003, 64'h0000_0000_0000_0000, 64'h0000_0000_0000_0022,
                  16'h0000, 16'hffff, 1'b0, 4'd0);
        add_entry(16'hffff, 64'h3333_3333_3333_3333, 64'h0123_4567_89ab_cdef,
                  16'h0000, 16'hfffd, 1'b0, 4'd2);
        foreach (stim[i]) run_entry(stim[i]);

        ready = '0;
        apb_read(reg_grant_count, data);
        check_reg(data, grant_count, "grant count");
        apb_read(reg_last_grant, data);
        check_reg(data, {28'd0, last_port}, "last grant");
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* verilog/switch_arbiter_top.sv */
module switch_arbiter_top
    import switch_cfg_pkg::*;
    import switch_hdr_pkg::*;
#(
    parameter int num_ports  = num_ports_default,
    parameter int num_levels = num_levels_default
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [num_ports*64-1:0]     hdr_words,
    input  logic [num_ports-1:0]        ready,
    input  logic [num_ports-1:0]        eop,
    input  logic [num_ports-1:0]        dest_busy,
    input  apb_req_t                    apb_req,
    output grant_t                      grant,
    output apb_rsp_t                    apb_rsp
);

    port_hdr_t [num_ports-1:0]              hdrs;
    logic [num_ports-1:0]                   hold_mask;
    logic                                   hdr_valid;
    logic [num_levels-1:0][num_ports-1:0]   level_mask;
    logic [num_ports-1:0]                   elig_mask;
    logic                                   release_hdr;
    logic [num_ports-1:0]                   port_enable;

    priority_decoder #(.num_ports(num_ports)) u_decoder (
        .clk(clk), .rst(rst), .hdr_words(hdr_words), .ready(ready),
        .release_hdr(release_hdr), .hdrs(hdrs), .hold_mask(hold_mask),
        .hdr_valid(hdr_valid)
    );

    priority_ranker #(.num_ports(num_ports), .num_levels(num_levels)) u_ranker (
        .hdrs(hdrs), .hold_mask(hold_mask), .level_mask(level_mask)
    );

    dest_filter #(.num_ports(num_ports)) u_filter (
        .hdrs(hdrs), .hold_mask(hold_mask), .dest_busy(dest_busy),
        .port_enable(port_enable), .elig_mask(elig_mask)
    );

    grant_select #(.num_ports(num_ports), .num_levels(num_levels)) u_select (
        .clk(clk), .rst(rst), .hdr_valid(hdr_valid), .level_mask(level_mask),
        .elig_mask(elig_mask), .hdrs(hdrs), .eop(eop), .grant(grant),
        .release_hdr(release_hdr)
    );

    apb_regs #(.num_ports(num_ports)) u_regs (
        .clk(clk), .rst(rst), .apb_req(apb_req), .grant(grant),
        .apb_rsp(apb_rsp), .port_enable(port_enable)
    );

endmodule

/* verilog/apb_regs.sv */
module apb_regs
    import switch_cfg_pkg::*;
    import switch_hdr_pkg::*;
#(
    parameter int num_ports = num_ports_default
) (
    input  logic                    clk,
    input  logic                    rst,
    input  apb_req_t                apb_req,
    input  grant_t                  grant,
    output apb_rsp_t                apb_rsp,
    output logic [num_ports-1:0]    port_enable
);

    logic        wr_access;
    logic        grant_valid_q;
    logic [31:0] grant_count;
    logic [3:0]  last_grant;

    assign wr_access = apb_req.psel && apb_req.penable && apb_req.pwrite;

    // ********************
    // registers
    // ********************

    always_ff @(posedge clk) begin
        if (rst) begin
            port_enable   <= '1;  // all ports on.
            grant_valid_q <= 1'b0;
            grant_count   <= '0;
            last_grant    <= '0;
        end else begin
            grant_valid_q <= grant.valid;
            if (wr_access && apb_req.paddr == reg_port_enable) begin
                port_enable <= apb_req.pwdata[num_ports-1:0];
            end
            if (grant.valid && !grant_valid_q) begin  // new grant.
                grant_count <= grant_count + 32'd1;
                last_grant  <= grant.port;
            end
        end
    end

    // read mux, valid in the access cycle.
    always_comb begin
        case (apb_req.paddr)
            reg_port_enable: apb_rsp.prdata = 32'(port_enable);
            reg_grant_count: apb_rsp.prdata = grant_count;
            reg_last_grant:  apb_rsp.prdata = {28'd0, last_grant};
            default:         apb_rsp.prdata = '0;
        endcase
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = 1'b0;
    end

endmodule

/* verilog/grant_select.sv */
module grant_select
    import switch_hdr_pkg::*;
#(
    parameter int num_ports  = num_ports_default,
    parameter int num_levels = num_levels_default
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    hdr_valid,
    input  logic [num_levels-1:0][num_ports-1:0]    level_mask,
    input  logic [num_ports-1:0]                    elig_mask,
    input  port_hdr_t [num_ports-1:0]               hdrs,
    input  logic [num_ports-1:0]                    eop,
    output grant_t                                  grant,
    output logic                                    release_hdr
);

    grant_state_e           state;
    logic [3:0]             rr_ptr;
    logic [num_ports-1:0]   cand;
    logic                   win_found;
    logic [3:0]             win_port;
    logic                   grant_done;

    // ********************
    // winner search
    // ********************

    always_comb begin
        int  idx;
        logic picked;

        cand      = '0;
        win_found = 1'b0;
        for (int l = num_levels - 1; l >= 0; l--) begin
            if (!win_found && |(level_mask[l] & elig_mask)) begin
                cand      = level_mask[l] & elig_mask;  // highest non-empty level.
                win_found = 1'b1;
            end
        end
        win_port = '0;
        picked   = 1'b0;
        for (int i = 0; i < num_ports; i++) begin
            idx = (int'(rr_ptr) + i) % num_ports;  // start at pointer, wrap.
            if (!picked && cand[idx]) begin
                win_port = 4'(idx);
                picked   = 1'b1;
            end
        end
    end

    assign grant_done  = (state == hold) && eop[grant.port];
    assign release_hdr = ((state == scan) && !win_found) || grant_done;

    // ********************
    // fsm
    // ********************

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= idle;
            rr_ptr      <= '0;
            grant.valid <= 1'b0;
        end else begin
            case (state)
                idle: if (hdr_valid) state <= scan;
                scan: begin
                    if (win_found) begin
                        grant.valid  <= 1'b1;
                        grant.port   <= win_port;
                        grant.dest   <= hdrs[win_port].dest;
                        grant.length <= hdrs[win_port].length;
                        state        <= hold;
                    end else begin
                        state <= idle;  // nothing eligible, fetch new headers.
                    end
                end
                hold: if (grant_done) begin
                    grant.valid <= 1'b0;
                    rr_ptr      <= (int'(grant.port) == num_ports - 1) ? 4'd0 : grant.port + 4'd1;
                    state       <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    a_grant_stable: assert property (
        @(posedge clk) disable iff (rst)
        grant.valid && !eop[grant.port] |=> grant.valid && $stable(grant.port)
    );

    // a grant always rests on captured headers.
    a_grant_needs_hdr: assert property (
        @(posedge clk) disable iff (rst) grant.valid |-> hdr_valid
    );

endmodule

/* verilog/dest_filter.sv */
module dest_filter
    import switch_hdr_pkg::*;
#(
    parameter int num_ports = num_ports_default
) (
    input  port_hdr_t [num_ports-1:0]   hdrs,
    input  logic [num_ports-1:0]        hold_mask,
    input  logic [num_ports-1:0]        dest_busy,
    input  logic [num_ports-1:0]        port_enable,
    output logic [num_ports-1:0]        elig_mask
);

    always_comb begin
        for (int p = 0; p < num_ports; p++) begin
            elig_mask[p] = hold_mask[p]
                        && port_enable[p]
                        && !dest_busy[hdrs[p].dest];  // output side must be free.
        end
    end

endmodule

/* verilog/priority_ranker.sv */
module priority_ranker
    import switch_hdr_pkg::*;
#(
    parameter int num_ports  = num_ports_default,
    parameter int num_levels = num_levels_default
) (
    input  port_hdr_t [num_ports-1:0]               hdrs,
    input  logic [num_ports-1:0]                    hold_mask,
    output logic [num_levels-1:0][num_ports-1:0]    level_mask
);

    // one mask per level, each held port lands in exactly one.
    always_comb begin
        for (int l = 0; l < num_levels; l++) begin
            for (int p = 0; p < num_ports; p++) begin
                level_mask[l][p] = hold_mask[p] && (hdrs[p].prio == 3'(l));
            end
        end
    end

endmodule

/* verilog/priority_decoder.sv */
module priority_decoder
    import switch_hdr_pkg::*;
#(
    parameter int num_ports = num_ports_default
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [num_ports*64-1:0]         hdr_words,
    input  logic [num_ports-1:0]            ready,
    input  logic                            release_hdr,
    output port_hdr_t [num_ports-1:0]       hdrs,
    output logic [num_ports-1:0]            hold_mask,
    output logic                            hdr_valid
);

    port_hdr_t [num_ports-1:0] fields;
    logic                      capture;

    // ********************
    // field extraction
    // ********************

    for (genvar p = 0; p < num_ports; p++) begin : g_split
        logic [63:0] word;

        assign word          = hdr_words[p*64 +: 64];
        assign fields[p].prio   = word[6:4];
        assign fields[p].dest   = word[3:0];
        assign fields[p].length = word[14:7];
    end

    assign capture = (|ready) && !hdr_valid;  // only when nothing is held.

    // ********************
    // capture and hold
    // ********************

    always_ff @(posedge clk) begin
        if (capture) begin
            hdrs <= fields;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_valid <= 1'b0;
            hold_mask <= '0;
        end else if (capture) begin
            hdr_valid <= 1'b1;
            hold_mask <= ready;  // snapshot of the ready flags.
        end else if (release_hdr) begin
            hdr_valid <= 1'b0;
        end
    end

    // the grant selector must only release what was captured.
    a_release_needs_valid: assert property (
        @(posedge clk) disable iff (rst) release_hdr |-> hdr_valid
    );

endmodule

/* verilog/switch_hdr_pkg.sv */
package switch_hdr_pkg;

    localparam int num_ports_default  = 16;
    localparam int num_levels_default = 8;

    // ********************
    // header fields
    // ********************

    // bits 6:4, 3:0 and 14:7 of the header word.
    typedef struct packed {
        logic [2:0] prio;
        logic [3:0] dest;
        logic [7:0] length;
    } port_hdr_t;

    typedef struct packed {
        logic       valid;
        logic [3:0] port;
        logic [3:0] dest;
        logic [7:0] length;
    } grant_t;

    // ********************
    // grant fsm
    // ********************

    typedef enum logic [1:0] {
        idle = 2'd0,
        scan = 2'd1,
        hold = 2'd2
    } grant_state_e;

endpackage

/* verilog/switch_cfg_pkg.sv */
package switch_cfg_pkg;

    // ********************
    // apb bus
    // ********************

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // register map.
    typedef enum logic [7:0] {
        reg_port_enable = 8'h00,  // rw, one bit per port.
        reg_grant_count = 8'h04,  // ro, grants issued.
        reg_last_grant  = 8'h08   // ro, port index in [3:0].
    } reg_addr_e;

endpackage
